// ==== design/fabric_settings.svh ====
`ifndef FABRIC_SETTINGS_SVH
`define FABRIC_SETTINGS_SVH

// Memory map.
`define ITIM_BASE 32'h0000_0000
`define DTIM_BASE 32'h0001_0000
`define TIM_MASK 32'h0000_0FFF

`define TIM_WORDS 1024

`define CLINT_BASE 32'h0200_0000
`define CLINT_MASK 32'h0000_FFFF

// Clock cycles per mtime increment.
`define CLINT_TICK_DIV 4

`endif

// ==== design/fabric_pkg.sv ====
package fabric_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;  // All zero on a read.
  typedef logic [63:0] time_t;

  typedef enum logic [1:0] {
    IDLE,
    BUSY_INSTR,
    BUSY_DATA
  } arb_state_t;

endpackage

// ==== design/tim.sv ====
`timescale 1ns/1ps

`include "fabric_settings.svh"

module tim (
  input  logic clock,
  input  logic reset,
  input  logic valid,
  input  fabric_pkg::addr_t addr,
  input  fabric_pkg::data_t wdata,
  input  fabric_pkg::strb_t wstrb,
  output logic ready,
  output fabric_pkg::data_t rdata
);

  localparam int INDEX_W = $clog2(`TIM_WORDS);

  fabric_pkg::data_t mem [0:`TIM_WORDS-1];
  logic [INDEX_W-1:0] index;

  assign index = addr[INDEX_W+1:2];  // Word index.

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      ready <= 1'b0;
    end else begin
      ready <= valid;
    end
  end

  always_ff @(posedge clock) begin
    if (valid) begin
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) mem[index][8*i +: 8] <= wdata[8*i +: 8];
      end
      rdata <= mem[index];  // Old contents on a write.
    end
  end

  // Rebasing upstream must keep the address inside the array.
  assert property (@(posedge clock) disable iff (reset == 0)
    valid |-> (addr >> 2) < `TIM_WORDS);

endmodule

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
  input  logic clock,
  input  logic reset,
  input  logic instr_valid,
  input  fabric_pkg::addr_t instr_addr,
  input  fabric_pkg::data_t instr_wdata,
  input  fabric_pkg::strb_t instr_wstrb,
  output logic instr_ready,
  output fabric_pkg::data_t instr_rdata,
  output logic instr_error,
  input  logic data_valid,
  input  fabric_pkg::addr_t data_addr,
  input  fabric_pkg::data_t data_wdata,
  input  fabric_pkg::strb_t data_wstrb,
  output logic data_ready,
  output fabric_pkg::data_t data_rdata,
  output logic data_error,
  output logic periph_valid,
  output fabric_pkg::addr_t periph_addr,
  output fabric_pkg::data_t periph_wdata,
  output fabric_pkg::strb_t periph_wstrb,
  input  logic periph_ready,
  input  fabric_pkg::data_t periph_rdata,
  input  logic periph_error
);

  fabric_pkg::arb_state_t state;

  logic instr_held;
  fabric_pkg::addr_t instr_addr_q;
  fabric_pkg::data_t instr_wdata_q;
  fabric_pkg::strb_t instr_wstrb_q;
  logic data_held;
  fabric_pkg::addr_t data_addr_q;
  fabric_pkg::data_t data_wdata_q;
  fabric_pkg::strb_t data_wstrb_q;
  logic issue_instr;
  logic issue_data;

  // Data wins a tie.
  assign issue_data = (state == fabric_pkg::IDLE) && data_held;
  assign issue_instr = (state == fabric_pkg::IDLE) && !data_held && instr_held;

  assign periph_valid = issue_data || issue_instr;
  assign periph_addr = issue_data ? data_addr_q : instr_addr_q;
  assign periph_wdata = issue_data ? data_wdata_q : instr_wdata_q;
  assign periph_wstrb = issue_data ? data_wstrb_q : instr_wstrb_q;

  // Response goes back to the owner of the bus.
  assign instr_ready = (state == fabric_pkg::BUSY_INSTR) && periph_ready;
  assign instr_rdata = periph_rdata;
  assign instr_error = instr_ready && periph_error;
  assign data_ready = (state == fabric_pkg::BUSY_DATA) && periph_ready;
  assign data_rdata = periph_rdata;
  assign data_error = data_ready && periph_error;

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      instr_held <= 1'b0;
      data_held <= 1'b0;
      state <= fabric_pkg::IDLE;
    end else begin
      if (instr_valid) instr_held <= 1'b1;
      else if (issue_instr) instr_held <= 1'b0;
      if (data_valid) data_held <= 1'b1;
      else if (issue_data) data_held <= 1'b0;
      case (state)
        fabric_pkg::IDLE: begin
          if (issue_data) state <= fabric_pkg::BUSY_DATA;
          else if (issue_instr) state <= fabric_pkg::BUSY_INSTR;
        end
        default: begin
          if (periph_ready) state <= fabric_pkg::IDLE;
        end
      endcase
    end
  end

  // Hold registers.
  always_ff @(posedge clock) begin
    if (instr_valid) begin
      instr_addr_q <= instr_addr;
      instr_wdata_q <= instr_wdata;
      instr_wstrb_q <= instr_wstrb;
    end
    if (data_valid) begin
      data_addr_q <= data_addr;
      data_wdata_q <= data_wdata;
      data_wstrb_q <= data_wstrb;
    end
  end

  // A response only arrives for an access in flight.
  assert property (@(posedge clock) disable iff (reset == 0)
    periph_ready |-> state != fabric_pkg::IDLE);

endmodule

// ==== design/periph_decoder.sv ====
`timescale 1ns/1ps

`include "fabric_settings.svh"

module periph_decoder (
  input  logic clock,
  input  logic reset,
  input  logic periph_valid,
  input  fabric_pkg::addr_t periph_addr,
  input  fabric_pkg::data_t periph_wdata,
  input  fabric_pkg::strb_t periph_wstrb,
  output logic periph_ready,
  output fabric_pkg::data_t periph_rdata,
  output logic periph_error,
  output logic clint_valid,
  output fabric_pkg::addr_t clint_addr,
  output fabric_pkg::data_t clint_wdata,
  output fabric_pkg::strb_t clint_wstrb,
  input  logic clint_ready,
  input  fabric_pkg::data_t clint_rdata
);

  logic clint_hit;
  logic error_ready;

  assign clint_hit = (periph_addr & ~`CLINT_MASK) == `CLINT_BASE;

  assign clint_valid = periph_valid && clint_hit;
  assign clint_addr = periph_addr - `CLINT_BASE;  // Offset into the clint.
  assign clint_wdata = periph_wdata;
  assign clint_wstrb = periph_wstrb;

  // Error responder for unmapped addresses.
  always_ff @(posedge clock) begin
    if (reset == 0) begin
      error_ready <= 1'b0;
    end else begin
      error_ready <= periph_valid && !clint_hit;
    end
  end

  assign periph_ready = clint_ready || error_ready;
  assign periph_rdata = error_ready ? '0 : clint_rdata;
  assign periph_error = error_ready;

  // Every target answers in one cycle.
  assert property (@(posedge clock) disable iff (reset == 0)
    periph_valid |=> periph_ready);

endmodule

// ==== design/clint.sv ====
`timescale 1ns/1ps

`include "fabric_settings.svh"

module clint (
  input  logic clock,
  input  logic reset,
  input  logic valid,
  input  fabric_pkg::addr_t addr,
  input  fabric_pkg::data_t wdata,
  input  fabric_pkg::strb_t wstrb,
  output logic ready,
  output fabric_pkg::data_t rdata,
  output logic msip,
  output logic mtip
);

  localparam logic [15:0] MSIP_OFF = 16'h0000;
  localparam logic [15:0] MTIMECMP_LO_OFF = 16'h4000;
  localparam logic [15:0] MTIMECMP_HI_OFF = 16'h4004;
  localparam logic [15:0] MTIME_LO_OFF = 16'hBFF8;
  localparam logic [15:0] MTIME_HI_OFF = 16'hBFFC;

  localparam int DIV_W = $clog2(`CLINT_TICK_DIV + 1);
  localparam logic [DIV_W-1:0] TICK_LAST = DIV_W'(`CLINT_TICK_DIV - 1);

  logic [DIV_W-1:0] tick_count;
  fabric_pkg::time_t mtime;
  fabric_pkg::time_t mtimecmp;
  fabric_pkg::data_t read_data;
  logic write;

  function automatic fabric_pkg::data_t merge(fabric_pkg::data_t old_word,
                                              fabric_pkg::data_t new_word,
                                              fabric_pkg::strb_t strb);
    fabric_pkg::data_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  assign write = valid && (wstrb != '0);

  always_comb begin
    case (addr[15:0])
      MSIP_OFF: read_data = {31'b0, msip};
      MTIMECMP_LO_OFF: read_data = mtimecmp[31:0];
      MTIMECMP_HI_OFF: read_data = mtimecmp[63:32];
      MTIME_LO_OFF: read_data = mtime[31:0];
      MTIME_HI_OFF: read_data = mtime[63:32];
      default: read_data = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      tick_count <= '0;
      mtime <= '0;
      mtimecmp <= '1;
      msip <= 1'b0;
      mtip <= 1'b0;
      ready <= 1'b0;
    end else begin
      ready <= valid;
      mtip <= mtime >= mtimecmp;
      if (tick_count == TICK_LAST) begin
        tick_count <= '0;
        mtime <= mtime + 1'b1;
      end else begin
        tick_count <= tick_count + 1'b1;
      end
      if (write) begin
        // A write to mtime takes precedence over the tick.
        case (addr[15:0])
          MSIP_OFF: if (wstrb[0]) msip <= wdata[0];
          MTIMECMP_LO_OFF: mtimecmp[31:0] <= merge(mtimecmp[31:0], wdata, wstrb);
          MTIMECMP_HI_OFF: mtimecmp[63:32] <= merge(mtimecmp[63:32], wdata, wstrb);
          MTIME_LO_OFF: mtime <= {mtime[63:32], merge(mtime[31:0], wdata, wstrb)};
          MTIME_HI_OFF: mtime <= {merge(mtime[63:32], wdata, wstrb), mtime[31:0]};
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (valid) rdata <= read_data;
  end

  // Offsets arrive rebased into the clint window.
  assert property (@(posedge clock) disable iff (reset == 0)
    valid |-> (addr & ~`CLINT_MASK) == '0);

endmodule

// ==== design/mem_fabric.sv ====
`timescale 1ns/1ps

`include "fabric_settings.svh"

module mem_fabric (
  input  logic clock,
  input  logic reset,
  input  logic instr_valid,
  input  fabric_pkg::addr_t instr_addr,
  input  fabric_pkg::data_t instr_wdata,
  input  fabric_pkg::strb_t instr_wstrb,
  output logic instr_ready,
  output fabric_pkg::data_t instr_rdata,
  output logic instr_error,
  input  logic data_valid,
  input  fabric_pkg::addr_t data_addr,
  input  fabric_pkg::data_t data_wdata,
  input  fabric_pkg::strb_t data_wstrb,
  output logic data_ready,
  output fabric_pkg::data_t data_rdata,
  output logic data_error,
  output logic msip,
  output logic mtip
);

  logic instr_itim_hit;
  logic instr_dtim_hit;
  logic data_itim_hit;
  logic data_dtim_hit;
  logic instr_itim;
  logic instr_dtim;
  logic instr_per;
  logic data_itim;
  logic data_dtim;
  logic data_per;

  logic pend_valid;
  logic pend_tim;  // Set for dtim.
  fabric_pkg::addr_t pend_addr;
  fabric_pkg::data_t pend_wdata;
  fabric_pkg::strb_t pend_wstrb;
  logic pend_itim;
  logic pend_dtim;

  logic itim_valid;
  fabric_pkg::addr_t itim_addr;
  fabric_pkg::data_t itim_wdata;
  fabric_pkg::strb_t itim_wstrb;
  logic itim_ready;
  fabric_pkg::data_t itim_rdata;
  logic dtim_valid;
  fabric_pkg::addr_t dtim_addr;
  fabric_pkg::data_t dtim_wdata;
  fabric_pkg::strb_t dtim_wstrb;
  logic dtim_ready;
  fabric_pkg::data_t dtim_rdata;

  // Route bits, set when the data port owns the access.
  logic itim_route;
  logic itim_route_q;
  logic dtim_route;
  logic dtim_route_q;

  logic arb_instr_ready;
  fabric_pkg::data_t arb_instr_rdata;
  logic arb_instr_error;
  logic arb_data_ready;
  fabric_pkg::data_t arb_data_rdata;
  logic arb_data_error;

  logic periph_valid;
  fabric_pkg::addr_t periph_addr;
  fabric_pkg::data_t periph_wdata;
  fabric_pkg::strb_t periph_wstrb;
  logic periph_ready;
  fabric_pkg::data_t periph_rdata;
  logic periph_error;

  logic clint_valid;
  fabric_pkg::addr_t clint_addr;
  fabric_pkg::data_t clint_wdata;
  fabric_pkg::strb_t clint_wstrb;
  logic clint_ready;
  fabric_pkg::data_t clint_rdata;

  function automatic logic in_tim(fabric_pkg::addr_t addr, fabric_pkg::addr_t base);
    return (addr & ~`TIM_MASK) == base;
  endfunction

  assign instr_itim_hit = in_tim(instr_addr, `ITIM_BASE);
  assign instr_dtim_hit = in_tim(instr_addr, `DTIM_BASE);
  assign data_itim_hit = in_tim(data_addr, `ITIM_BASE);
  assign data_dtim_hit = in_tim(data_addr, `DTIM_BASE);

  assign instr_itim = instr_valid && instr_itim_hit;
  assign instr_dtim = instr_valid && instr_dtim_hit;
  assign instr_per = instr_valid && !instr_itim_hit && !instr_dtim_hit;
  assign data_itim = data_valid && data_itim_hit;
  assign data_dtim = data_valid && data_dtim_hit;
  assign data_per = data_valid && !data_itim_hit && !data_dtim_hit;

  assign pend_itim = pend_valid && !pend_tim;
  assign pend_dtim = pend_valid && pend_tim;

  // Itim steering, instruction port first after the pending slot.
  always_comb begin
    itim_valid = pend_itim || instr_itim || data_itim;
    itim_route = itim_route_q;
    itim_addr = instr_addr - `ITIM_BASE;
    itim_wdata = instr_wdata;
    itim_wstrb = instr_wstrb;
    if (pend_itim) begin
      itim_route = 1'b1;
      itim_addr = pend_addr;
      itim_wdata = pend_wdata;
      itim_wstrb = pend_wstrb;
    end else if (instr_itim) begin
      itim_route = 1'b0;
    end else if (data_itim) begin
      itim_route = 1'b1;
      itim_addr = data_addr - `ITIM_BASE;
      itim_wdata = data_wdata;
      itim_wstrb = data_wstrb;
    end
  end

  // Dtim steering, data port first after the pending slot.
  always_comb begin
    dtim_valid = pend_dtim || data_dtim || instr_dtim;
    dtim_route = dtim_route_q;
    dtim_addr = data_addr - `DTIM_BASE;
    dtim_wdata = data_wdata;
    dtim_wstrb = data_wstrb;
    if (pend_dtim) begin
      dtim_route = 1'b0;
      dtim_addr = pend_addr;
      dtim_wdata = pend_wdata;
      dtim_wstrb = pend_wstrb;
    end else if (data_dtim) begin
      dtim_route = 1'b1;
    end else if (instr_dtim) begin
      dtim_route = 1'b0;
      dtim_addr = instr_addr - `DTIM_BASE;
      dtim_wdata = instr_wdata;
      dtim_wstrb = instr_wstrb;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      pend_valid <= 1'b0;
      pend_tim <= 1'b0;
      itim_route_q <= 1'b0;
      dtim_route_q <= 1'b0;
    end else begin
      pend_valid <= (instr_itim && data_itim) || (instr_dtim && data_dtim);
      pend_tim <= instr_dtim && data_dtim;
      itim_route_q <= itim_route;
      dtim_route_q <= dtim_route;
    end
  end

  // Losing request of a same-TIM conflict.
  always_ff @(posedge clock) begin
    if (instr_itim && data_itim) begin
      pend_addr <= data_addr - `ITIM_BASE;
      pend_wdata <= data_wdata;
      pend_wstrb <= data_wstrb;
    end else if (instr_dtim && data_dtim) begin
      pend_addr <= instr_addr - `DTIM_BASE;
      pend_wdata <= instr_wdata;
      pend_wstrb <= instr_wstrb;
    end
  end

  always_comb begin
    instr_ready = 1'b0;
    instr_rdata = '0;
    instr_error = 1'b0;
    if (itim_ready && !itim_route_q) begin
      instr_ready = 1'b1;
      instr_rdata = itim_rdata;
    end
    if (dtim_ready && !dtim_route_q) begin
      instr_ready = 1'b1;
      instr_rdata = dtim_rdata;
    end
    if (arb_instr_ready) begin
      instr_ready = 1'b1;
      instr_rdata = arb_instr_rdata;
      instr_error = arb_instr_error;
    end
  end

  always_comb begin
    data_ready = 1'b0;
    data_rdata = '0;
    data_error = 1'b0;
    if (itim_ready && itim_route_q) begin
      data_ready = 1'b1;
      data_rdata = itim_rdata;
    end
    if (dtim_ready && dtim_route_q) begin
      data_ready = 1'b1;
      data_rdata = dtim_rdata;
    end
    if (arb_data_ready) begin
      data_ready = 1'b1;
      data_rdata = arb_data_rdata;
      data_error = arb_data_error;
    end
  end

  tim itim_inst (
    .clock(clock),
    .reset(reset),
    .valid(itim_valid),
    .addr(itim_addr),
    .wdata(itim_wdata),
    .wstrb(itim_wstrb),
    .ready(itim_ready),
    .rdata(itim_rdata)
  );

  tim dtim_inst (
    .clock(clock),
    .reset(reset),
    .valid(dtim_valid),
    .addr(dtim_addr),
    .wdata(dtim_wdata),
    .wstrb(dtim_wstrb),
    .ready(dtim_ready),
    .rdata(dtim_rdata)
  );

  bus_arbiter bus_arbiter_inst (
    .clock(clock),
    .reset(reset),
    .instr_valid(instr_per),
    .instr_addr(instr_addr),
    .instr_wdata(instr_wdata),
    .instr_wstrb(instr_wstrb),
    .instr_ready(arb_instr_ready),
    .instr_rdata(arb_instr_rdata),
    .instr_error(arb_instr_error),
    .data_valid(data_per),
    .data_addr(data_addr),
    .data_wdata(data_wdata),
    .data_wstrb(data_wstrb),
    .data_ready(arb_data_ready),
    .data_rdata(arb_data_rdata),
    .data_error(arb_data_error),
    .periph_valid(periph_valid),
    .periph_addr(periph_addr),
    .periph_wdata(periph_wdata),
    .periph_wstrb(periph_wstrb),
    .periph_ready(periph_ready),
    .periph_rdata(periph_rdata),
    .periph_error(periph_error)
  );

  periph_decoder periph_decoder_inst (
    .clock(clock),
    .reset(reset),
    .periph_valid(periph_valid),
    .periph_addr(periph_addr),
    .periph_wdata(periph_wdata),
    .periph_wstrb(periph_wstrb),
    .periph_ready(periph_ready),
    .periph_rdata(periph_rdata),
    .periph_error(periph_error),
    .clint_valid(clint_valid),
    .clint_addr(clint_addr),
    .clint_wdata(clint_wdata),
    .clint_wstrb(clint_wstrb),
    .clint_ready(clint_ready),
    .clint_rdata(clint_rdata)
  );

  clint clint_inst (
    .clock(clock),
    .reset(reset),
    .valid(clint_valid),
    .addr(clint_addr),
    .wdata(clint_wdata),
    .wstrb(clint_wstrb),
    .ready(clint_ready),
    .rdata(clint_rdata),
    .msip(msip),
    .mtip(mtip)
  );

endmodule

// ==== verification/mem_fabric_tb.sv ====
`timescale 1ns/1ps

`include "fabric_settings.svh"

module mem_fabric_tb;

  localparam int NUM_TESTS = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 2000;
  localparam int READY_LIMIT = 64;
  localparam int RANDOM_ACCESSES = 200;
  localparam int HALF_WORDS = `TIM_WORDS / 2;

  // Clint register map.
  localparam fabric_pkg::addr_t MSIP_ADDR = `CLINT_BASE + 32'h0000;
  localparam fabric_pkg::addr_t MTIMECMP_LO_ADDR = `CLINT_BASE + 32'h4000;
  localparam fabric_pkg::addr_t MTIMECMP_HI_ADDR = `CLINT_BASE + 32'h4004;
  localparam fabric_pkg::addr_t MTIME_LO_ADDR = `CLINT_BASE + 32'hBFF8;

  logic clock;
  logic reset = 1'b0;
  logic instr_valid = 1'b0;
  fabric_pkg::addr_t instr_addr = '0;
  fabric_pkg::data_t instr_wdata = '0;
  fabric_pkg::strb_t instr_wstrb = '0;
  logic instr_ready;
  fabric_pkg::data_t instr_rdata;
  logic instr_error;
  logic data_valid = 1'b0;
  fabric_pkg::addr_t data_addr = '0;
  fabric_pkg::data_t data_wdata = '0;
  fabric_pkg::strb_t data_wstrb = '0;
  logic data_ready;
  fabric_pkg::data_t data_rdata;
  logic data_error;
  logic msip;
  logic mtip;

  fabric_pkg::data_t itim_model [0:`TIM_WORDS-1];
  fabric_pkg::data_t dtim_model [0:`TIM_WORDS-1];
  logic [31:0] lfsr = 32'h7601;
  int errors = 0;
  int tests_done = 0;
  int cycle = 0;

  // Expected response per port, 0 is instr and 1 is data.
  logic busy [2] = '{1'b0, 1'b0};
  logic check_rdata [2] = '{1'b0, 1'b0};
  fabric_pkg::data_t exp_rdata [2] = '{32'h0, 32'h0};
  logic exp_error [2] = '{1'b0, 1'b0};

  mem_fabric mem_fabric_inst (
    .clock(clock),
    .reset(reset),
    .instr_valid(instr_valid),
    .instr_addr(instr_addr),
    .instr_wdata(instr_wdata),
    .instr_wstrb(instr_wstrb),
    .instr_ready(instr_ready),
    .instr_rdata(instr_rdata),
    .instr_error(instr_error),
    .data_valid(data_valid),
    .data_addr(data_addr),
    .data_wdata(data_wdata),
    .data_wstrb(data_wstrb),
    .data_ready(data_ready),
    .data_rdata(data_rdata),
    .data_error(data_error),
    .msip(msip),
    .mtip(mtip)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) cycle <= cycle + 1;

  // Response checks on both ports.
  assert property (@(posedge clock) disable iff (reset == 0) instr_ready |-> busy[0])
    else begin
      errors++;
      $display("instr_ready pulsed at %0t with no request outstanding", $time);
    end
  assert property (@(posedge clock) disable iff (reset == 0) data_ready |-> busy[1])
    else begin
      errors++;
      $display("data_ready pulsed at %0t with no request outstanding", $time);
    end
  assert property (@(posedge clock) disable iff (reset == 0)
    instr_ready |-> instr_error == exp_error[0])
    else begin
      errors++;
      $display("Error at %0t: instr_error is %b, expected %b", $time,
               $sampled(instr_error), $sampled(exp_error[0]));
    end
  assert property (@(posedge clock) disable iff (reset == 0)
    data_ready |-> data_error == exp_error[1])
    else begin
      errors++;
      $display("Error at %0t: data_error is %b, expected %b", $time,
               $sampled(data_error), $sampled(exp_error[1]));
    end
  assert property (@(posedge clock) disable iff (reset == 0)
    instr_ready && check_rdata[0] |-> instr_rdata == exp_rdata[0])
    else begin
      errors++;
      $display("Error at %0t: instr_rdata is %h, expected %h", $time,
               $sampled(instr_rdata), $sampled(exp_rdata[0]));
    end
  assert property (@(posedge clock) disable iff (reset == 0)
    data_ready && check_rdata[1] |-> data_rdata == exp_rdata[1])
    else begin
      errors++;
      $display("Error at %0t: data_rdata is %h, expected %h", $time,
               $sampled(data_rdata), $sampled(exp_rdata[1]));
    end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per bit.
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  function automatic fabric_pkg::data_t fill_pattern(input fabric_pkg::addr_t addr);
    return (addr * 32'h9E37_79B9) ^ 32'h5A5A_A5A5;
  endfunction

  function automatic fabric_pkg::data_t apply_strobes(input fabric_pkg::data_t old_word,
                                                      input fabric_pkg::data_t new_word,
                                                      input fabric_pkg::strb_t strb);
    fabric_pkg::data_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  task automatic expect_value(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
    assert (got === expected)
      else begin
        errors++;
        $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, expected);
      end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_done++;
    $display("Test %0d %s finished with %0d errors", tests_done, name,
             errors - errors_before);
  endtask

  // One request on a port, then wait for its ready.
  task automatic access(input int port, input fabric_pkg::addr_t addr,
                        input fabric_pkg::data_t wdata, input fabric_pkg::strb_t wstrb,
                        input logic check, input fabric_pkg::data_t rdata_exp,
                        input logic error_exp, output fabric_pkg::data_t rdata);
    int waited;
    logic seen;
    waited = 0;
    seen = 1'b0;
    @(posedge clock);
    busy[port] = 1'b1;
    check_rdata[port] = check;
    exp_rdata[port] = rdata_exp;
    exp_error[port] = error_exp;
    if (port == 0) begin
      instr_valid <= 1'b1;
      instr_addr <= addr;
      instr_wdata <= wdata;
      instr_wstrb <= wstrb;
    end else begin
      data_valid <= 1'b1;
      data_addr <= addr;
      data_wdata <= wdata;
      data_wstrb <= wstrb;
    end
    @(posedge clock);
    if (port == 0) instr_valid <= 1'b0;
    else data_valid <= 1'b0;
    while (!seen && waited < READY_LIMIT) begin
      @(posedge clock);
      waited++;
      seen = (port == 0) ? instr_ready : data_ready;
    end
    rdata = (port == 0) ? instr_rdata : data_rdata;
    busy[port] = 1'b0;
    if (!seen) begin
      errors++;
      $display("%s port got no ready within %0d cycles for address %h at %0t",
               (port == 0) ? "instr" : "data", READY_LIMIT, addr, $time);
    end
  endtask

  task automatic tim_access(input int port, input logic dtim, input int word,
                            input fabric_pkg::data_t wdata, input fabric_pkg::strb_t wstrb);
    fabric_pkg::addr_t addr;
    fabric_pkg::data_t expected;
    fabric_pkg::data_t rdata;
    addr = (dtim ? `DTIM_BASE : `ITIM_BASE) + 32'(word) * 4;
    if (dtim) begin
      expected = dtim_model[word];
      dtim_model[word] = apply_strobes(expected, wdata, wstrb);
    end else begin
      expected = itim_model[word];
      itim_model[word] = apply_strobes(expected, wdata, wstrb);
    end
    access(port, addr, wdata, wstrb, wstrb == 4'h0, expected, 1'b0, rdata);
  endtask

  task automatic check_reset_values();
    int errors_before;
    errors_before = errors;
    expect_value("instr_ready", 64'(instr_ready), 64'd0);
    expect_value("data_ready", 64'(data_ready), 64'd0);
    expect_value("msip", 64'(msip), 64'd0);
    expect_value("mtip", 64'(mtip), 64'd0);
    report_test("reset_values", errors_before);
  endtask

  task automatic random_tim_traffic();
    int errors_before;
    logic dtim [2];
    int word [2];
    fabric_pkg::data_t wdata [2];
    fabric_pkg::strb_t wstrb [2];
    errors_before = errors;
    for (int w = 0; w < `TIM_WORDS; w++) begin
      fork
        tim_access(0, 1'b0, w, fill_pattern(`ITIM_BASE + 32'(w) * 4), 4'hF);
        tim_access(1, 1'b1, w, fill_pattern(`DTIM_BASE + 32'(w) * 4), 4'hF);
      join
    end
    for (int i = 0; i < RANDOM_ACCESSES; i++) begin
      for (int p = 0; p < 2; p++) begin
        dtim[p] = 1'(random_bits(1));
        word[p] = p * HALF_WORDS + int'(random_bits(9));  // Each port owns half.
        wstrb[p] = (random_bits(1) != 0) ? 4'(random_bits(4)) : 4'h0;
        wdata[p] = random_bits(32);
      end
      fork
        tim_access(0, dtim[0], word[0], wdata[0], wstrb[0]);
        tim_access(1, dtim[1], word[1], wdata[1], wstrb[1]);
      join
    end
    report_test("random_tim_traffic", errors_before);
  endtask

  task automatic tim_conflicts();
    int errors_before;
    logic dtim;
    int w0;
    int w1;
    fabric_pkg::data_t d0;
    fabric_pkg::data_t d1;
    errors_before = errors;
    for (int k = 0; k < 16; k++) begin
      dtim = (k % 2) == 1;
      w0 = int'(random_bits(9));
      w1 = HALF_WORDS + int'(random_bits(9));
      d0 = random_bits(32);
      d1 = random_bits(32);
      fork
        tim_access(0, dtim, w0, d0, 4'hF);
        tim_access(1, dtim, w1, d1, 4'hF);
      join
      // Cross reads.
      fork
        tim_access(0, dtim, w1, '0, 4'h0);
        tim_access(1, dtim, w0, '0, 4'h0);
      join
    end
    report_test("tim_conflicts", errors_before);
  endtask

  task automatic unmapped_accesses();
    int errors_before;
    int w;
    fabric_pkg::addr_t far;
    fabric_pkg::data_t r0;
    fabric_pkg::data_t r1;
    errors_before = errors;
    for (int k = 0; k < 4; k++) begin
      w = int'(random_bits(10));
      fork
        // Just past the end of each TIM window.
        access(0, `ITIM_BASE + 32'h1000 + 32'(w) * 4, random_bits(32), 4'hF, 1'b1, '0, 1'b1, r0);
        access(1, `DTIM_BASE + 32'h1000 + 32'(w) * 4, random_bits(32), 4'hF, 1'b1, '0, 1'b1, r1);
      join
      far = {4'h8, 26'(random_bits(26)), 2'b00};
      fork
        access(0, far, '0, 4'h0, 1'b1, '0, 1'b1, r0);
        access(1, far ^ 32'h0100_0000, '0, 4'h0, 1'b1, '0, 1'b1, r1);
      join
      fork
        tim_access(0, 1'b0, w, '0, 4'h0);
        tim_access(1, 1'b1, w, '0, 4'h0);
      join
    end
    report_test("unmapped_accesses", errors_before);
  endtask

  task automatic clint_msip_mtime();
    int errors_before;
    int start;
    int gap;
    int diff;
    fabric_pkg::data_t rdata;
    fabric_pkg::data_t t1;
    fabric_pkg::data_t t2;
    errors_before = errors;
    access(1, MSIP_ADDR, 32'h1, 4'hF, 1'b0, '0, 1'b0, rdata);
    expect_value("msip", 64'(msip), 64'd1);
    access(0, MSIP_ADDR, '0, 4'h0, 1'b1, 32'h1, 1'b0, rdata);
    access(1, MSIP_ADDR, 32'h0, 4'hF, 1'b0, '0, 1'b0, rdata);
    expect_value("msip", 64'(msip), 64'd0);
    start = cycle;
    access(1, MTIME_LO_ADDR, '0, 4'h0, 1'b0, '0, 1'b0, t1);
    repeat (100) @(posedge clock);
    gap = cycle - start;
    access(1, MTIME_LO_ADDR, '0, 4'h0, 1'b0, '0, 1'b0, t2);
    diff = int'(t2 - t1);
    assert (diff <= gap / `CLINT_TICK_DIV + 1 && diff >= gap / `CLINT_TICK_DIV - 1)
      else begin
        errors++;
        $display("mtime moved by %0d ticks over %0d cycles", diff, gap);
      end
    report_test("clint_msip_mtime", errors_before);
  endtask

  task automatic clint_timer_compare();
    int errors_before;
    int waited;
    fabric_pkg::data_t t1;
    fabric_pkg::data_t r0;
    fabric_pkg::data_t r1;
    errors_before = errors;
    access(1, MTIME_LO_ADDR, '0, 4'h0, 1'b0, '0, 1'b0, t1);
    access(1, MTIMECMP_LO_ADDR, t1 + 32'd20, 4'hF, 1'b0, '0, 1'b0, r1);
    access(1, MTIMECMP_HI_ADDR, 32'h0, 4'hF, 1'b0, '0, 1'b0, r1);
    expect_value("mtip", 64'(mtip), 64'd0);
    waited = 0;
    while (!mtip && waited < 24 * `CLINT_TICK_DIV) begin
      @(posedge clock);
      waited++;
    end
    assert (mtip)
      else begin
        errors++;
        $display("mtip did not rise within %0d cycles of the mtimecmp write", waited);
      end
    access(0, MTIMECMP_HI_ADDR, 32'hFFFF_FFFF, 4'hF, 1'b0, '0, 1'b0, r0);
    access(0, MTIMECMP_LO_ADDR, 32'hFFFF_FFFF, 4'hF, 1'b0, '0, 1'b0, r0);
    repeat (2) @(posedge clock);
    expect_value("mtip", 64'(mtip), 64'd0);
    fork
      access(0, MTIMECMP_HI_ADDR, '0, 4'h0, 1'b1, 32'hFFFF_FFFF, 1'b0, r0);
      access(1, MSIP_ADDR, '0, 4'h0, 1'b1, 32'h0, 1'b0, r1);
    join
    report_test("clint_timer_compare", errors_before);
  endtask

  initial begin
    repeat (16) @(posedge clock);
    reset <= 1'b1;
    @(posedge clock);
    check_reset_values();
    random_tim_traffic();
    tim_conflicts();
    unmapped_accesses();
    clint_msip_mtime();
    clint_timer_compare();
    $display("Summary: %0d tests run, %0d errors", tests_done, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+design
design/fabric_pkg.sv
design/tim.sv
design/bus_arbiter.sv
design/periph_decoder.sv
design/clint.sv
design/mem_fabric.sv
verification/mem_fabric_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory fabric testbench.

VERILATOR ?= verilator
TOP ?= mem_fabric_tb
RTL_TOP ?= mem_fabric
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
